// ==== compile.f ====
+incdir+hw
hw/riscv_pkg.sv
hw/misalign_check.sv
hw/store_align.sv
hw/load_align.sv
hw/lsu_ctrl.sv
hw/lsu_top.sv
dv/mem_model.sv
dv/tb_lsu_top.sv

// ==== dv/mem_model.sv ====
//##########################################################
// Byte-enabled memory for the LSU testbench, one transfer at
// a time with seeded random ready and valid delays
//##########################################################

`timescale 1ns/1ns

`include "lsu_config.svh"

module mem_model #(
	parameter logic [31:0] seed_init = 32'h1
) (
	input  logic                   CLK,
	input  logic                   RSTn,
	input  logic                   mem_req,
	input  logic                   mem_we,
	input  logic [`LSU_XLEN-1:0]   mem_addr,
	input  logic [`LSU_XLEN-1:0]   mem_wdata,
	input  logic [`LSU_NBYTES-1:0] mem_be,
	output logic                   mem_rdy,
	output logic                   mem_valid,
	output logic [`LSU_XLEN-1:0]   mem_rdata
);

	localparam int depth = 256;

	logic [7:0]           mem [0:depth-1];
	// Advanced by every $random call
	integer               seed = seed_init;
	integer               r;
	// Accepted transfer still waiting for its valid pulse
	logic                 pending;
	logic [1:0]           delay;
	logic [7:0]           base;
	logic [7:0]           idx;
	logic [`LSU_XLEN-1:0] rd_word;

	always @(posedge CLK) begin
		r = $random(seed);
		if (!RSTn) begin
			mem_rdy   <= 1'b0;
			mem_valid <= 1'b0;
			mem_rdata <= '0;
			pending   <= 1'b0;
			delay     <= 2'd0;
			// Fill pattern, a function of the byte address
			for (int i = 0; i < depth; i++) begin
				mem[i] <= 8'(i * 29 + 71);
			end
		end else begin
			mem_valid <= 1'b0;
			if (pending) begin
				if (delay == 2'd0) begin
					mem_valid <= 1'b1;
					pending   <= 1'b0;
				end else begin
					delay <= delay - 2'd1;
				end
			end else if (mem_req && mem_rdy) begin
				// Accepted: the write lands and the read word is taken now
				base = {mem_addr[7:2], 2'b00};
				for (int k = 0; k < `LSU_NBYTES; k++) begin
					idx = base + 8'(k);
					if (mem_we && mem_be[k]) begin
						mem[idx] <= mem_wdata[8*k +: 8];
					end
					rd_word[8*k +: 8] = mem[idx];
				end
				mem_rdata <= rd_word;
				pending   <= 1'b1;
				delay     <= r[3:2];
				mem_rdy   <= 1'b0;
			end else begin
				// Ready about three cycles in four
				mem_rdy <= (r[1:0] != 2'b00);
			end
		end
	end

endmodule

// ==== dv/tb_lsu_top.sv ====
//##########################################################
// Table-driven LSU testbench that plays core and hazard unit
// and checks results against a shadow copy of the memory
//##########################################################

`timescale 1ns/1ns

`include "lsu_config.svh"

module tb_lsu_top import riscv_pkg::*; ();

	localparam int depth   = 256;
	localparam int timeout = 40;

	typedef struct packed {
		mem_ctrl_t              ctrl;
		logic [`LSU_XLEN-1:0]   addr;
		logic [`LSU_XLEN-1:0]   data;
		// hz_data_req held low
		logic                   req_low;
		logic [`LSU_XLEN-1:0]   exp_data;
		logic                   exp_err;
		logic                   exp_req;
		logic [`LSU_NBYTES-1:0] exp_be;
		logic [`LSU_XLEN-1:0]   exp_wdata;
	} entry_t;

	logic                   CLK;
	logic                   RSTn;
	logic                   hz_data_req;
	mem_ctrl_t              mem_ctrl;
	logic [`LSU_XLEN-1:0]   addr_in;
	logic [`LSU_XLEN-1:0]   data_in;
	logic                   busy;
	logic                   err;
	logic [`LSU_XLEN-1:0]   data_out;
	logic                   mem_req;
	logic                   mem_we;
	logic [`LSU_XLEN-1:0]   mem_addr;
	logic [`LSU_XLEN-1:0]   mem_wdata;
	logic [`LSU_NBYTES-1:0] mem_be;
	logic                   mem_rdy;
	logic                   mem_valid;
	logic [`LSU_XLEN-1:0]   mem_rdata;

	// Expected memory bytes and last load result
	logic [7:0]             shadow [0:depth-1];
	logic [`LSU_XLEN-1:0]   last_load;
	entry_t                 stim_q[$];

	lsu_top u_dut (.*);

	mem_model #(.seed_init(32'h68a4)) u_mem (.*);

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	task automatic check_bit(input string name, input logic got, input logic exp);
		assert (got === exp) else begin
			$display("** Error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	task automatic check_word(input string name, input logic [`LSU_XLEN-1:0] got,
			input logic [`LSU_XLEN-1:0] exp);
		assert (got === exp) else begin
			$display("** Error at %0t ns: %s is 0x%h, expected 0x%h", $time, name, got, exp);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	task automatic check_true(input logic cond, input string msg);
		assert (cond) else begin
			$display("%s at %0t ns", msg, $time);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	function automatic int size_bytes(input mem_size_t s);
		case (s)
			size_byte: return 1;
			size_half: return 2;
			default:   return 4;
		endcase
	endfunction

	// Bit mask of the lanes selected by the byte enables
	function automatic logic [`LSU_XLEN-1:0] lane_mask(input logic [`LSU_NBYTES-1:0] be);
		logic [`LSU_XLEN-1:0] m;
		for (int k = 0; k < `LSU_NBYTES; k++) begin
			m[8*k +: 8] = {8{be[k]}};
		end
		return m;
	endfunction

	function automatic mem_ctrl_t make_ctrl(input logic en, input logic wr, input mem_size_t s,
			input logic uns);
		mem_ctrl_t c;
		c.mem_en      = en;
		c.wr          = wr;
		c.size        = s;
		c.is_unsigned = uns;
		return c;
	endfunction

	// Expected values from the alignment and extension rules
	task automatic add_entry(input mem_ctrl_t c, input logic [`LSU_XLEN-1:0] a,
			input logic [`LSU_XLEN-1:0] d, input logic req_low);
		entry_t               e;
		int                   n;
		logic [7:0]           idx;
		logic [1:0]           lane;
		logic [`LSU_XLEN-1:0] v;
		logic [`LSU_XLEN-1:0] fill;
		logic [`LSU_XLEN-1:0] top;
		n         = size_bytes(c.size);
		e.ctrl    = c;
		e.addr    = a;
		e.data    = d;
		e.req_low = req_low;
		e.exp_err = c.mem_en && !req_low && ((n == 2 && a[0]) || (n == 4 && a[1:0] != 2'b00));
		e.exp_req = c.mem_en && !req_low && !e.exp_err;
		e.exp_be    = '0;
		e.exp_wdata = '0;
		v = '0;
		for (int j = 0; j < n; j++) begin
			idx  = a[7:0] + 8'(j);
			// Byte lane of the byte address
			lane = idx[1:0];
			e.exp_be[lane]           = 1'b1;
			e.exp_wdata[8*lane +: 8] = d[8*j +: 8];
			if (e.exp_req && c.wr) begin
				shadow[idx] = d[8*j +: 8];
			end
			v[8*j +: 8] = shadow[idx];
		end
		// Sign fill above the loaded bytes and none for a full word
		fill = ~((`LSU_XLEN'(1) << (8 * n)) - `LSU_XLEN'(1));
		top  = v >> (8 * n - 1);
		if (!c.is_unsigned && top[0]) begin
			v = v | fill;
		end
		if (e.exp_req && !c.wr) begin
			last_load = v;
		end
		e.exp_data = last_load;
		stim_q.push_back(e);
	endtask

	task automatic add_store(input mem_size_t s, input logic [`LSU_XLEN-1:0] a,
			input logic [`LSU_XLEN-1:0] d);
		add_entry(make_ctrl(1'b1, 1'b1, s, 1'b0), a, d, 1'b0);
	endtask

	task automatic add_load(input mem_size_t s, input logic uns, input logic [`LSU_XLEN-1:0] a);
		add_entry(make_ctrl(1'b1, 1'b0, s, uns), a, '0, 1'b0);
	endtask

	task automatic build_table();
		add_store(size_word, 32'h40, 32'hdeadbeef);
		add_load(size_word, 1'b0, 32'h40);
		// Lanes 1 and 3 of a known word with upper data bits ignored
		add_store(size_word, 32'h48, 32'h01234567);
		add_store(size_byte, 32'h49, 32'hffffff80);
		add_store(size_byte, 32'h4b, 32'h0000a57e);
		add_load(size_word, 1'b0, 32'h48);
		add_load(size_byte, 1'b0, 32'h49);
		add_load(size_byte, 1'b1, 32'h49);
		add_load(size_byte, 1'b0, 32'h4b);
		add_load(size_byte, 1'b1, 32'h48);
		// Lanes 0 and 2 over the fill pattern
		add_store(size_byte, 32'h44, 32'h000000c3);
		add_store(size_byte, 32'h46, 32'h0000003c);
		add_load(size_word, 1'b0, 32'h44);
		add_load(size_byte, 1'b0, 32'h44);
		add_load(size_byte, 1'b1, 32'h47);
		add_store(size_half, 32'h4c, 32'h12348001);
		add_store(size_half, 32'h4e, 32'h00007ffe);
		add_load(size_word, 1'b0, 32'h4c);
		add_load(size_half, 1'b0, 32'h4c);
		add_load(size_half, 1'b1, 32'h4c);
		add_load(size_half, 1'b0, 32'h4e);
		add_load(size_half, 1'b1, 32'h4e);
		// A store keeps the last load result
		add_store(size_word, 32'h50, 32'h0badf00d);
		// Misaligned accesses that never reach memory
		add_store(size_half, 32'h41, 32'h0000ffff);
		add_load(size_word, 1'b0, 32'h42);
		add_store(size_word, 32'h43, 32'h11111111);
		add_load(size_half, 1'b1, 32'h47);
		add_load(size_word, 1'b0, 32'h40);
		add_load(size_half, 1'b0, 32'h82);
		add_load(size_byte, 1'b0, 32'ha3);
		// Request held off and then mem_en low
		add_entry(make_ctrl(1'b1, 1'b0, size_word, 1'b0), 32'h48, '0, 1'b1);
		add_entry(make_ctrl(1'b0, 1'b1, size_word, 1'b0), 32'h48, 32'hffffffff, 1'b0);
		add_entry(make_ctrl(1'b1, 1'b0, size_half, 1'b0), 32'h41, '0, 1'b1);
		add_load(size_word, 1'b0, 32'h48);
	endtask

	task automatic drive(input mem_ctrl_t c, input logic [`LSU_XLEN-1:0] a,
			input logic [`LSU_XLEN-1:0] d, input logic req);
		@(posedge CLK);
		mem_ctrl    <= c;
		addr_in     <= a;
		data_in     <= d;
		hz_data_req <= req;
	endtask

	task automatic run_entry(input entry_t e);
		int   n;
		logic accepted;
		drive(e.ctrl, e.addr, e.data, !e.req_low);
		// Launch cycle
		@(negedge CLK);
		if (e.exp_req) begin
			check_bit("busy", busy, 1'b1);
			check_bit("mem_we", mem_we, e.ctrl.wr);
			check_word("mem_addr", mem_addr, e.addr);
			check_word("mem_be", `LSU_XLEN'(mem_be), `LSU_XLEN'(e.exp_be));
			if (e.ctrl.wr) begin
				check_word("mem_wdata", mem_wdata & lane_mask(e.exp_be), e.exp_wdata);
			end
			accepted = 1'b0;
			n = 0;
			while (busy) begin
				check_bit("mem_req", mem_req, !accepted);
				accepted = accepted || (mem_req && mem_rdy);
				n++;
				check_true(n < timeout, "Timeout waiting for busy to fall");
				@(negedge CLK);
			end
			check_true(accepted, "busy fell before memory accepted the request");
			check_bit("mem_valid", mem_valid, 1'b1);
			check_bit("mem_req", mem_req, 1'b0);
			drive(make_ctrl(1'b0, 1'b0, size_byte, 1'b0), '0, '0, 1'b0);
			@(negedge CLK);
		end else if (e.exp_err) begin
			check_bit("mem_req", mem_req, 1'b0);
			check_bit("busy", busy, 1'b0);
			check_bit("err", err, 1'b0);
			drive(make_ctrl(1'b0, 1'b0, size_byte, 1'b0), '0, '0, 1'b0);
			n = 1;
			@(negedge CLK);
			while (!err) begin
				n++;
				check_true(n < timeout, "Timeout waiting for err");
				@(negedge CLK);
			end
			check_true(n == 1, "err did not rise in the cycle after the launch");
			check_bit("mem_req", mem_req, 1'b0);
			@(negedge CLK);
			check_bit("err", err, 1'b0);
		end else begin
			// Several quiet cycles
			for (int k = 0; k < 4; k++) begin
				check_bit("mem_req", mem_req, 1'b0);
				check_bit("busy", busy, 1'b0);
				check_bit("err", err, 1'b0);
				@(negedge CLK);
			end
			drive(make_ctrl(1'b0, 1'b0, size_byte, 1'b0), '0, '0, 1'b0);
			@(negedge CLK);
		end
		check_word("data_out", data_out, e.exp_data);
	endtask

	initial begin
		RSTn        <= 1'b0;
		hz_data_req <= 1'b0;
		mem_ctrl    <= '0;
		addr_in     <= '0;
		data_in     <= '0;
		last_load = '0;
		for (int i = 0; i < depth; i++) begin
			shadow[i] = 8'(i * 29 + 71);
		end
		build_table();
		repeat (3) @(posedge CLK);
		RSTn <= 1'b1;
		@(negedge CLK);
		check_bit("mem_req", mem_req, 1'b0);
		check_bit("busy", busy, 1'b0);
		check_bit("err", err, 1'b0);
		check_word("data_out", data_out, '0);
		foreach (stim_q[i]) begin
			run_entry(stim_q[i]);
		end
		$display("Test completed successfully");
		$finish;
	end

endmodule

// ==== hw/load_align.sv ====
//##########################################################
// Load data path: picks the addressed byte or half from the
// read word, extends it and holds the result for the core
//##########################################################

`timescale 1ns/1ns

`include "lsu_config.svh"

module load_align import riscv_pkg::*; (
	input  logic                           CLK,
	input  logic                           RSTn,

	// From lsu_ctrl, mem_valid of a pending load
	input  logic                           capture,
	input  logic [`LSU_XLEN-1:0]           mem_rdata,

	// Access info, stable until busy falls
	input  logic [$clog2(`LSU_NBYTES)-1:0] addr_lo,
	input  mem_size_t                      size,
	input  logic                           is_unsigned,

	output logic [`LSU_XLEN-1:0]           data_out
);

	// Read word shifted so the addressed lane sits at bit 0
	logic [`LSU_XLEN-1:0] shifted;
	logic [7:0]           byte_sel;
	logic [15:0]          half_sel;
	// Fill bit for the upper part
	logic                 sign_bit;
	logic [`LSU_XLEN-1:0] extended;

	assign shifted  = mem_rdata >> {addr_lo, 3'b000};
	assign byte_sel = shifted[7:0];
	assign half_sel = shifted[15:0];

	always_comb begin
		case (size)
			size_byte: begin
				sign_bit = !is_unsigned && byte_sel[7];
				extended = {{(`LSU_XLEN - 8){sign_bit}}, byte_sel};
			end
			size_half: begin
				sign_bit = !is_unsigned && half_sel[15];
				extended = {{(`LSU_XLEN - 16){sign_bit}}, half_sel};
			end
			default: begin
				// Full word, nothing to extend
				sign_bit = 1'b0;
				extended = mem_rdata;
			end
		endcase
	end

	// Result held until the next load completes
	// Stores leave it untouched
	always_ff @(posedge CLK) begin
		if (!RSTn) begin
			data_out <= '0;
		end else if (capture) begin
			data_out <= extended;
		end
	end

endmodule

// ==== hw/lsu_config.svh ====
//##########################################################
// Data path sizing of the LSU, include where widths are used
//##########################################################

`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// Address and data width
// RV32 only, one word per memory transfer
`define LSU_XLEN 32

// Byte lanes per word
// Must stay LSU_XLEN / 8
`define LSU_NBYTES 4

`endif

// ==== hw/lsu_ctrl.sv ====
//##########################################################
// LSU control FSM: launches one memory transfer at a time,
// drives busy for the hazard unit and flags misalignment
//##########################################################

`timescale 1ns/1ns

module lsu_ctrl (
	input  logic CLK,
	input  logic RSTn,

	// Core side
	input  logic hz_data_req,
	input  logic mem_en,
	input  logic wr,
	input  logic misaligned,
	output logic busy,
	output logic err,

	// Memory handshake
	input  logic mem_rdy,
	input  logic mem_valid,
	output logic mem_req,

	// Sample strobe for load_align
	output logic capture
);

	typedef enum logic [1:0] {
		st_idle,
		st_wait_ready,
		st_wait_valid
	} state_t;

	state_t state;
	state_t next_state;

	// Core asks for an access while nothing is in flight
	logic launch;
	// Launch that actually reaches the memory
	logic go;

	assign launch = (state == st_idle) && hz_data_req && mem_en;
	assign go     = launch && !misaligned;

	always_ff @(posedge CLK) begin
		if (!RSTn) begin
			state <= st_idle;
		end else begin
			state <= next_state;
		end
	end

	// Error pulse one cycle after a misaligned launch
	always_ff @(posedge CLK) begin
		if (!RSTn) begin
			err <= 1'b0;
		end else begin
			err <= launch && misaligned;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			st_idle: begin
				// Accepted in the launch cycle if memory is ready
				if (go) begin
					next_state = mem_rdy ? st_wait_valid : st_wait_ready;
				end
			end
			st_wait_ready: begin
				if (mem_rdy) begin
					next_state = st_wait_valid;
				end
			end
			st_wait_valid: begin
				// One valid pulse per transfer, reads and writes alike
				if (mem_valid) begin
					next_state = st_idle;
				end
			end
			default: begin
				next_state = st_idle;
			end
		endcase
	end

	// Request held until the accepting cycle
	assign mem_req = go || (state == st_wait_ready);

	// Busy drops combinationally with mem_valid so the core
	// resumes in the same cycle
	assign busy = go
		|| (state == st_wait_ready)
		|| ((state == st_wait_valid) && !mem_valid);

	// wr is held stable by the core until busy falls
	assign capture = (state == st_wait_valid) && mem_valid && !wr;

endmodule

// ==== hw/lsu_top.sv ====
//##########################################################
// Load and store unit top: core enable/busy side on one end,
// memory req/ready/valid side on the other
//##########################################################

`timescale 1ns/1ns

`include "lsu_config.svh"

module lsu_top import riscv_pkg::*; (
	input  logic                   CLK,
	input  logic                   RSTn,

	// Core side
	input  logic                   hz_data_req,
	input  mem_ctrl_t              mem_ctrl,
	input  logic [`LSU_XLEN-1:0]   addr_in,
	input  logic [`LSU_XLEN-1:0]   data_in,
	output logic                   busy,
	output logic                   err,
	output logic [`LSU_XLEN-1:0]   data_out,

	// Memory side
	input  logic                   mem_rdy,
	input  logic                   mem_valid,
	input  logic [`LSU_XLEN-1:0]   mem_rdata,
	output logic                   mem_req,
	output logic                   mem_we,
	output logic [`LSU_XLEN-1:0]   mem_addr,
	output logic [`LSU_XLEN-1:0]   mem_wdata,
	output logic [`LSU_NBYTES-1:0] mem_be
);

	localparam int lo_w = $clog2(`LSU_NBYTES);

	logic [lo_w-1:0] addr_lo;
	logic            misaligned;
	logic            capture;

	// Byte offset shared by the checker and both aligners
	assign addr_lo = addr_in[lo_w-1:0];

	// Full byte address and direction go straight to memory
	assign mem_addr = addr_in;
	assign mem_we   = mem_ctrl.wr;

	lsu_ctrl u_ctrl (
		.CLK         (CLK),
		.RSTn        (RSTn),
		.hz_data_req (hz_data_req),
		.mem_en      (mem_ctrl.mem_en),
		.wr          (mem_ctrl.wr),
		.misaligned  (misaligned),
		.busy        (busy),
		.err         (err),
		.mem_rdy     (mem_rdy),
		.mem_valid   (mem_valid),
		.mem_req     (mem_req),
		.capture     (capture)
	);

	misalign_check u_misalign (
		.addr_lo    (addr_lo),
		.size       (mem_ctrl.size),
		.misaligned (misaligned)
	);

	store_align u_store (
		.data_in   (data_in),
		.addr_lo   (addr_lo),
		.size      (mem_ctrl.size),
		.mem_wdata (mem_wdata),
		.mem_be    (mem_be)
	);

	load_align u_load (
		.CLK         (CLK),
		.RSTn        (RSTn),
		.capture     (capture),
		.mem_rdata   (mem_rdata),
		.addr_lo     (addr_lo),
		.size        (mem_ctrl.size),
		.is_unsigned (mem_ctrl.is_unsigned),
		.data_out    (data_out)
	);

endmodule

// ==== hw/misalign_check.sv ====
//##########################################################
// Alignment check of a load or store address against the
// access size, combinational, feeds the control FSM
//##########################################################

`timescale 1ns/1ns

`include "lsu_config.svh"

module misalign_check import riscv_pkg::*; (
	// Low address bits, byte offset within the word
	input  logic [$clog2(`LSU_NBYTES)-1:0] addr_lo,
	input  mem_size_t                      size,
	output logic                           misaligned
);

	always_comb begin
		case (size)
			// Any byte lane is fine
			size_byte: begin
				misaligned = 1'b0;
			end
			// Halves on even addresses only
			size_half: begin
				misaligned = addr_lo[0];
			end
			// Words need both low bits clear
			size_word: begin
				misaligned = |addr_lo;
			end
			// Unused size code, refuse it like a bad address
			default: begin
				misaligned = 1'b1;
			end
		endcase
	end

endmodule

// ==== hw/riscv_pkg.sv ====
//##########################################################
// Access size and memory control word types of the LSU
// Imported by every module that uses them
//##########################################################

package riscv_pkg;

	// Access size of a load or store
	// Encoding matches funct3[1:0] of the RV32I memory instructions
	typedef enum logic [1:0] {
		size_byte = 2'b00,
		size_half = 2'b01,
		size_word = 2'b10
	} mem_size_t;

	// Memory control word sent with every instruction
	// 5 bits wide with mem_en in the MSB
	typedef struct packed {
		// Instruction touches memory
		logic       mem_en;
		// Store when set, load otherwise
		logic       wr;
		// Byte, half or word
		mem_size_t  size;
		// Zero-extend on load (LBU, LHU)
		logic       is_unsigned;
	} mem_ctrl_t;

endpackage

// ==== hw/store_align.sv ====
//##########################################################
// Store lane steering: replicates store data across the word
// and builds the byte enables for the addressed lanes
//##########################################################

`timescale 1ns/1ns

`include "lsu_config.svh"

module store_align import riscv_pkg::*; (
	input  logic [`LSU_XLEN-1:0]           data_in,
	input  logic [$clog2(`LSU_NBYTES)-1:0] addr_lo,
	input  mem_size_t                      size,
	output logic [`LSU_XLEN-1:0]           mem_wdata,
	output logic [`LSU_NBYTES-1:0]         mem_be
);

	// Alignment is checked upstream, addr_lo trusted here
	always_comb begin
		case (size)
			size_byte: begin
				// Low byte copied to every lane
				mem_wdata = {`LSU_NBYTES{data_in[7:0]}};
				mem_be    = `LSU_NBYTES'(1) << addr_lo;
			end
			size_half: begin
				// Low half copied to both half lanes
				mem_wdata = {(`LSU_NBYTES / 2){data_in[15:0]}};
				mem_be    = `LSU_NBYTES'(3) << addr_lo;
			end
			size_word: begin
				mem_wdata = data_in;
				mem_be    = '1;
			end
			default: begin
				// No lanes enabled for an unknown size
				mem_wdata = data_in;
				mem_be    = '0;
			end
		endcase
	end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the LSU testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 \
	--top-module tb_lsu_top \
	-Mdir obj_dir \
	-f compile.f
./obj_dir/Vtb_lsu_top
